// File: eth_rx_cfg.svh
`ifndef ETH_RX_CFG_SVH
`define ETH_RX_CFG_SVH

// MAC header bytes following the SFD (destination, source, ethertype)
`define ETH_HEADER_BYTES 14

// seven 55h bytes then D5h, first byte at the bottom of the window
`define ETH_PREAMBLE_SFD 64'hD555555555555555

// CRC-32 register after a good frame plus its FCS has passed through
`define ETH_FCS_RESIDUE 32'hDEBB20E3

// packet FIFO geometry
`define ETH_RX_FIFO_DEPTH 64
`define ETH_RX_FIFO_AW 6

`define ETH_COUNT_WIDTH 16

`endif

// File: eth_types_pkg.sv
package eth_types_pkg;

    // #########################################################################
    // frame format
    // #########################################################################

    // one GMII or stream byte
    typedef logic [7:0] byte_t;

    // first byte on the wire sits in the top bits
    typedef logic [47:0] mac_addr_t;

    // reflected CRC-32 register
    typedef logic [31:0] crc_t;

endpackage

// File: eth_rx_ctrl_pkg.sv
`include "eth_rx_cfg.svh"

package eth_rx_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE_SFD,
        HEADER,
        PAYLOAD
    } parser_state_t;

    // extra top bit tells full from empty
    typedef logic [`ETH_RX_FIFO_AW:0] fifo_ptr_t;

    typedef logic [`ETH_COUNT_WIDTH-1:0] count_t;

endpackage

// File: eth_frame_parser.sv
`timescale 1ns/100ps

`include "eth_rx_cfg.svh"

module eth_frame_parser (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  eth_types_pkg::byte_t     rx_d_i,
    input  logic                     rx_dv_i,
    input  eth_types_pkg::mac_addr_t station_mac_i,
    input  logic                     promisc_i,
    output eth_types_pkg::byte_t     pb_data_o,
    output logic                     pb_valid_o,
    output logic                     pb_last_o,
    output logic                     pb_payload_o,
    output logic                     pb_match_o
);

    localparam int HDR_CW = $clog2(`ETH_HEADER_BYTES);

    eth_types_pkg::byte_t [2:0]     rxd_z;
    logic [2:0]                     rxdv_z;
    logic                           frame_start;
    logic                           frame_end;

    eth_rx_ctrl_pkg::parser_state_t state_q;
    logic [63:0]                    window_q;
    logic [63:0]                    window_nxt;
    logic [HDR_CW-1:0]              hdr_cnt;
    eth_types_pkg::mac_addr_t       dest_q;

    // #########################################################################
    // input delay line
    // #########################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxdv_z <= '0;
        end else begin
            rxdv_z <= {rxdv_z[1:0], rx_dv_i};
        end
    end

    always_ff @(posedge clk_i) begin
        rxd_z <= {rxd_z[1:0], rx_d_i};
    end

    // start seen one stage early so the FSM is ready for the first byte
    assign frame_start = rxdv_z[1] & ~rxdv_z[2];
    // byte in stage 2 is the final one of the frame
    assign frame_end   = rxdv_z[2] & ~rxdv_z[1];

    assign window_nxt = {rxd_z[2], window_q[63:8]};

    // #########################################################################
    // frame FSM
    // #########################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= eth_rx_ctrl_pkg::IDLE;
            hdr_cnt    <= '0;
            pb_valid_o <= 1'b0;
            pb_last_o  <= 1'b0;
            pb_match_o <= 1'b0;
        end else begin
            pb_valid_o <= 1'b0;
            pb_last_o  <= 1'b0;
            case (state_q)
                eth_rx_ctrl_pkg::IDLE: begin
                    pb_match_o <= 1'b0;
                    if (frame_start) begin
                        state_q <= eth_rx_ctrl_pkg::PREAMBLE_SFD;
                    end
                end
                eth_rx_ctrl_pkg::PREAMBLE_SFD: begin
                    hdr_cnt <= '0;
                    if (frame_end) begin
                        state_q <= eth_rx_ctrl_pkg::IDLE;
                    end else if (window_nxt == `ETH_PREAMBLE_SFD) begin
                        state_q <= eth_rx_ctrl_pkg::HEADER;
                    end
                end
                eth_rx_ctrl_pkg::HEADER: begin
                    pb_valid_o <= 1'b1;
                    pb_last_o  <= frame_end;
                    hdr_cnt    <= hdr_cnt + 1'b1;
                    // destination is complete once byte 5 is in
                    if (hdr_cnt == HDR_CW'(6)) begin
                        pb_match_o <= promisc_i | (dest_q == station_mac_i);
                    end
                    if (frame_end) begin
                        state_q <= eth_rx_ctrl_pkg::IDLE;
                    end else if (hdr_cnt == HDR_CW'(`ETH_HEADER_BYTES - 1)) begin
                        state_q <= eth_rx_ctrl_pkg::PAYLOAD;
                    end
                end
                default: begin
                    pb_valid_o <= 1'b1;
                    pb_last_o  <= frame_end;
                    if (frame_end) begin
                        state_q <= eth_rx_ctrl_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        pb_data_o    <= rxd_z[2];
        pb_payload_o <= (state_q == eth_rx_ctrl_pkg::PAYLOAD);
        window_q     <= (state_q == eth_rx_ctrl_pkg::PREAMBLE_SFD) ? window_nxt : '0;
        if (state_q == eth_rx_ctrl_pkg::HEADER && hdr_cnt < HDR_CW'(6)) begin
            dest_q <= {dest_q[39:0], rxd_z[2]};
        end
    end

endmodule

// File: eth_fcs_checker.sv
`timescale 1ns/100ps

`include "eth_rx_cfg.svh"

module eth_fcs_checker (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  eth_types_pkg::byte_t pb_data_i,
    input  logic                 pb_valid_i,
    input  logic                 pb_last_i,
    input  logic                 pb_payload_i,
    input  logic                 pb_match_i,
    output eth_types_pkg::byte_t cb_data_o,
    output logic                 cb_valid_o,
    output logic                 cb_last_o,
    output logic                 cb_payload_o,
    output logic                 cb_match_o,
    output logic                 cb_fcs_ok_o
);

    localparam eth_types_pkg::crc_t CRC_POLY = 32'hEDB88320;

    eth_types_pkg::crc_t       crc_q;
    eth_types_pkg::crc_t       crc_upd;
    eth_types_pkg::byte_t [3:0] dl_data;
    logic [3:0]                dl_payload;
    logic [3:0]                dl_match;
    logic [3:0]                dl_vld;

    // reflected CRC-32, one byte LSB first
    function automatic eth_types_pkg::crc_t crc_byte(input eth_types_pkg::crc_t crc,
                                                     input eth_types_pkg::byte_t data);
        eth_types_pkg::crc_t r;
        r = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    assign crc_upd = crc_byte(crc_q, pb_data_i);

    // #########################################################################
    // CRC and delay line control
    // #########################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            crc_q       <= '1;
            dl_vld      <= '0;
            cb_valid_o  <= 1'b0;
            cb_last_o   <= 1'b0;
            cb_fcs_ok_o <= 1'b0;
        end else begin
            cb_valid_o  <= 1'b0;
            cb_last_o   <= 1'b0;
            cb_fcs_ok_o <= 1'b0;
            if (pb_valid_i) begin
                // register goes back to all ones for the next frame
                crc_q <= pb_last_i ? '1 : crc_upd;
                if (pb_last_i) begin
                    cb_valid_o  <= 1'b1;
                    cb_last_o   <= 1'b1;
                    cb_fcs_ok_o <= (crc_upd == `ETH_FCS_RESIDUE);
                    dl_vld      <= '0;
                end else begin
                    cb_valid_o <= dl_vld[3];
                    dl_vld     <= {dl_vld[2:0], 1'b1};
                end
            end
        end
    end

    // oldest entry leaves once four newer bytes are in, so the FCS never does
    always_ff @(posedge clk_i) begin
        if (pb_valid_i) begin
            dl_data      <= {dl_data[2:0], pb_data_i};
            dl_payload   <= {dl_payload[2:0], pb_payload_i};
            dl_match     <= {dl_match[2:0], pb_match_i};
            cb_data_o    <= dl_data[3];
            cb_payload_o <= dl_vld[3] & dl_payload[3];
            cb_match_o   <= dl_vld[3] ? dl_match[3] : pb_match_i;
        end
    end

endmodule

// File: eth_rx_fifo.sv
`timescale 1ns/100ps

`include "eth_rx_cfg.svh"

module eth_rx_fifo (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  eth_types_pkg::byte_t    cb_data_i,
    input  logic                    cb_valid_i,
    input  logic                    cb_last_i,
    input  logic                    cb_payload_i,
    input  logic                    cb_match_i,
    input  logic                    cb_fcs_ok_i,
    output eth_types_pkg::byte_t    out_data_o,
    output logic                    out_valid_o,
    output logic                    out_last_o,
    input  logic                    out_ready_i,
    output eth_rx_ctrl_pkg::count_t rx_good_count_o,
    output eth_rx_ctrl_pkg::count_t rx_bad_count_o,
    output eth_rx_ctrl_pkg::count_t rx_overflow_count_o
);

    localparam int AW = `ETH_RX_FIFO_AW;

    eth_types_pkg::byte_t       mem_data [`ETH_RX_FIFO_DEPTH];
    logic                       mem_last [`ETH_RX_FIFO_DEPTH];

    eth_rx_ctrl_pkg::fifo_ptr_t wr_ptr;
    eth_rx_ctrl_pkg::fifo_ptr_t cm_ptr;
    eth_rx_ctrl_pkg::fifo_ptr_t rd_ptr;
    logic                       ovf_q;
    logic                       accept;
    logic                       full;
    logic                       wr_en;
    logic                       ovf_now;
    logic                       frame_good;
    logic                       load;

    // payload byte of a frame addressed to us
    assign accept     = cb_valid_i & cb_payload_i & cb_match_i;
    assign full       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_en      = accept & ~ovf_q & ~full;
    assign ovf_now    = ovf_q | (accept & full);
    assign frame_good = cb_payload_i & cb_fcs_ok_i & ~ovf_now;
    // read side only sees committed frames
    assign load       = (cm_ptr != rd_ptr) & (~out_valid_o | out_ready_i);

    // #########################################################################
    // write side, commit and rollback
    // #########################################################################

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_data[wr_ptr[AW-1:0]] <= cb_data_i;
            mem_last[wr_ptr[AW-1:0]] <= cb_last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr              <= '0;
            cm_ptr              <= '0;
            ovf_q               <= 1'b0;
            rx_good_count_o     <= '0;
            rx_bad_count_o      <= '0;
            rx_overflow_count_o <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (accept & full) begin
                ovf_q <= 1'b1;
            end
            if (cb_valid_i & cb_last_i) begin
                ovf_q <= 1'b0;
                if (cb_match_i) begin
                    if (frame_good) begin
                        cm_ptr          <= wr_ptr + 1'b1;
                        rx_good_count_o <= rx_good_count_o + 1'b1;
                    end else begin
                        // drop everything since the last commit
                        wr_ptr <= cm_ptr;
                        if (ovf_now) begin
                            rx_overflow_count_o <= rx_overflow_count_o + 1'b1;
                        end else begin
                            rx_bad_count_o <= rx_bad_count_o + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // #########################################################################
    // read side
    // #########################################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr      <= '0;
            out_valid_o <= 1'b0;
            out_last_o  <= 1'b0;
        end else if (load) begin
            rd_ptr      <= rd_ptr + 1'b1;
            out_valid_o <= 1'b1;
            out_last_o  <= mem_last[rd_ptr[AW-1:0]];
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data_o <= mem_data[rd_ptr[AW-1:0]];
        end
    end

endmodule

// File: eth_rx_top.sv
`timescale 1ns/100ps

module eth_rx_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  eth_types_pkg::byte_t     rx_d_i,
    input  logic                     rx_dv_i,
    input  eth_types_pkg::mac_addr_t station_mac_i,
    input  logic                     promisc_i,
    output eth_types_pkg::byte_t     out_data_o,
    output logic                     out_valid_o,
    output logic                     out_last_o,
    input  logic                     out_ready_i,
    output eth_rx_ctrl_pkg::count_t  rx_good_count_o,
    output eth_rx_ctrl_pkg::count_t  rx_bad_count_o,
    output eth_rx_ctrl_pkg::count_t  rx_overflow_count_o
);

    // parser to checker
    eth_types_pkg::byte_t pb_data;
    logic                 pb_valid;
    logic                 pb_last;
    logic                 pb_payload;
    logic                 pb_match;

    // checker to FIFO
    eth_types_pkg::byte_t cb_data;
    logic                 cb_valid;
    logic                 cb_last;
    logic                 cb_payload;
    logic                 cb_match;
    logic                 cb_fcs_ok;

    eth_frame_parser eth_frame_parser_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rx_d_i        (rx_d_i),
        .rx_dv_i       (rx_dv_i),
        .station_mac_i (station_mac_i),
        .promisc_i     (promisc_i),
        .pb_data_o     (pb_data),
        .pb_valid_o    (pb_valid),
        .pb_last_o     (pb_last),
        .pb_payload_o  (pb_payload),
        .pb_match_o    (pb_match)
    );

    eth_fcs_checker eth_fcs_checker_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .pb_data_i    (pb_data),
        .pb_valid_i   (pb_valid),
        .pb_last_i    (pb_last),
        .pb_payload_i (pb_payload),
        .pb_match_i   (pb_match),
        .cb_data_o    (cb_data),
        .cb_valid_o   (cb_valid),
        .cb_last_o    (cb_last),
        .cb_payload_o (cb_payload),
        .cb_match_o   (cb_match),
        .cb_fcs_ok_o  (cb_fcs_ok)
    );

    eth_rx_fifo eth_rx_fifo_inst (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .cb_data_i           (cb_data),
        .cb_valid_i          (cb_valid),
        .cb_last_i           (cb_last),
        .cb_payload_i        (cb_payload),
        .cb_match_i          (cb_match),
        .cb_fcs_ok_i         (cb_fcs_ok),
        .out_data_o          (out_data_o),
        .out_valid_o         (out_valid_o),
        .out_last_o          (out_last_o),
        .out_ready_i         (out_ready_i),
        .rx_good_count_o     (rx_good_count_o),
        .rx_bad_count_o      (rx_bad_count_o),
        .rx_overflow_count_o (rx_overflow_count_o)
    );

endmodule

// File: eth_rx_props.sv
`timescale 1ns/100ps

module eth_rx_props (
    input logic                    clk_i,
    input logic                    rst_i,
    input eth_types_pkg::byte_t    out_data_o,
    input logic                    out_valid_o,
    input logic                    out_last_o,
    input logic                    out_ready_i,
    input eth_rx_ctrl_pkg::count_t rx_good_count_o,
    input eth_rx_ctrl_pkg::count_t rx_bad_count_o,
    input eth_rx_ctrl_pkg::count_t rx_overflow_count_o
);

    a_valid_in_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
        else $error("out_valid_o high after a reset cycle");

    // stream holds while the receiver stalls
    a_hold_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_last_o))
        else $error("output stream changed while stalled");

    a_good_mono: assert property (@(posedge clk_i) disable iff (rst_i)
        rx_good_count_o >= $past(rx_good_count_o))
        else $error("rx_good_count_o decreased");

    a_bad_mono: assert property (@(posedge clk_i) disable iff (rst_i)
        rx_bad_count_o >= $past(rx_bad_count_o))
        else $error("rx_bad_count_o decreased");

    a_ovf_mono: assert property (@(posedge clk_i) disable iff (rst_i)
        rx_overflow_count_o >= $past(rx_overflow_count_o))
        else $error("rx_overflow_count_o decreased");

endmodule

bind eth_rx_top eth_rx_props eth_rx_props_inst (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .out_data_o          (out_data_o),
    .out_valid_o         (out_valid_o),
    .out_last_o          (out_last_o),
    .out_ready_i         (out_ready_i),
    .rx_good_count_o     (rx_good_count_o),
    .rx_bad_count_o      (rx_bad_count_o),
    .rx_overflow_count_o (rx_overflow_count_o)
);

// File: tb_eth_rx.sv
`timescale 1ns/100ps

`include "eth_rx_cfg.svh"

module tb_eth_rx;

    localparam eth_types_pkg::mac_addr_t STATION_MAC = 48'h02_11_22_33_44_55;
    localparam eth_types_pkg::mac_addr_t OTHER_MAC   = 48'h02_00_00_00_00_99;
    localparam eth_types_pkg::mac_addr_t SRC_MAC     = 48'h02_AA_BB_CC_DD_EE;
    localparam int IFG         = 12;
    localparam int DRAIN_LIMIT = 4000;

    logic                     clk_i;
    logic                     rst_i;
    eth_types_pkg::byte_t     rx_d_i;
    logic                     rx_dv_i;
    eth_types_pkg::mac_addr_t station_mac_i;
    logic                     promisc_i;
    eth_types_pkg::byte_t     out_data_o;
    logic                     out_valid_o;
    logic                     out_last_o;
    logic                     out_ready_i = 1'b0;
    eth_rx_ctrl_pkg::count_t  rx_good_count_o;
    eth_rx_ctrl_pkg::count_t  rx_bad_count_o;
    eth_rx_ctrl_pkg::count_t  rx_overflow_count_o;

    eth_types_pkg::byte_t     exp_data[$];
    logic                     exp_last[$];
    eth_rx_ctrl_pkg::count_t  exp_good = '0;
    eth_rx_ctrl_pkg::count_t  exp_bad = '0;
    eth_rx_ctrl_pkg::count_t  exp_ovf = '0;
    int                       ready_mode = 0;
    int                       errors = 0;
    int                       checks = 0;
    int                       test_base = 0;
    int                       plen;

    eth_rx_top eth_rx_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // 0 ready always, 1 ready three cycles in four, 2 stalled
    always @(posedge clk_i) begin
        case (ready_mode)
            0: out_ready_i <= 1'b1;
            1: out_ready_i <= (($urandom % 4) != 0);
            default: out_ready_i <= 1'b0;
        endcase
    end

    // reflected CRC-32 with final inversion, bit by bit
    function automatic eth_types_pkg::crc_t crc32_ref(input eth_types_pkg::byte_t data[$]);
        eth_types_pkg::crc_t crc;
        logic                fb;
        crc = '1;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ data[i][b];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hEDB88320;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic check_byte(input string name, input eth_types_pkg::byte_t got,
                              input eth_types_pkg::byte_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%02h expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input eth_rx_ctrl_pkg::count_t got,
                               input eth_rx_ctrl_pkg::count_t exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%04h expected 0x%04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_counters();
        check_count("rx_good_count_o", rx_good_count_o, exp_good);
        check_count("rx_bad_count_o", rx_bad_count_o, exp_bad);
        check_count("rx_overflow_count_o", rx_overflow_count_o, exp_ovf);
    endtask

    // cut > 0 truncates the frame to that many bytes after the SFD, with no FCS
    task automatic send_frame(input eth_types_pkg::mac_addr_t dest, input int len,
                              input bit bad_fcs, input int cut, input bit deliver);
        eth_types_pkg::byte_t fr[$];
        eth_types_pkg::byte_t b;
        eth_types_pkg::crc_t  fcs;
        for (int i = 0; i < 6; i++) begin
            fr.push_back(dest[47 - 8 * i -: 8]);
        end
        for (int i = 0; i < 6; i++) begin
            fr.push_back(SRC_MAC[47 - 8 * i -: 8]);
        end
        fr.push_back(8'h08);
        fr.push_back(8'h00);
        for (int i = 0; i < len; i++) begin
            b = 8'($urandom);
            fr.push_back(b);
            if (deliver) begin
                exp_data.push_back(b);
                exp_last.push_back(i == len - 1);
            end
        end
        if (cut > 0) begin
            while (fr.size() > cut) begin
                void'(fr.pop_back());
            end
        end else begin
            fcs = crc32_ref(fr);
            for (int i = 0; i < 4; i++) begin
                fr.push_back(fcs[8 * i +: 8]);
            end
            if (bad_fcs) begin
                fr[fr.size() - 2] = fr[fr.size() - 2] ^ 8'h04;
            end
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_i);
            rx_dv_i <= 1'b1;
            rx_d_i  <= (i == 7) ? 8'hD5 : 8'h55;
        end
        foreach (fr[i]) begin
            @(posedge clk_i);
            rx_d_i <= fr[i];
        end
        @(posedge clk_i);
        rx_dv_i <= 1'b0;
        rx_d_i  <= 8'h00;
        // gap also covers the pipeline latency up to the counter update
        repeat (IFG) @(posedge clk_i);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_data.size() != 0 || out_valid_o) && cycles < DRAIN_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_data.size() != 0 || out_valid_o) begin
            $display("timeout: output stream did not drain, %0d bytes still expected",
                     exp_data.size());
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_base);
        test_base = errors;
    endtask

    // a byte moves on an edge where valid and ready are both high
    initial begin
        forever begin
            @(negedge clk_i);
            if (!rst_i && out_valid_o && out_ready_i) begin
                if (exp_data.size() == 0) begin
                    $display("output byte 0x%02h arrived with no frame expected", out_data_o);
                    errors++;
                end else begin
                    check_byte("out_data_o", out_data_o, exp_data.pop_front());
                    check_flag("out_last_o", out_last_o, exp_last.pop_front());
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h30e0));
        rst_i         = 1'b1;
        rx_d_i        = 8'h00;
        rx_dv_i       = 1'b0;
        station_mac_i = STATION_MAC;
        promisc_i     = 1'b0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (2) @(posedge clk_i);

        plen = 1 + int'($urandom % 40);
        send_frame(STATION_MAC, plen, 1'b0, 0, 1'b1);
        exp_good = exp_good + 1'b1;
        wait_drain();
        check_counters();
        report_test(1, "good frame to station");

        send_frame(OTHER_MAC, 20, 1'b0, 0, 1'b0);
        wait_drain();
        check_counters();
        promisc_i <= 1'b1;
        send_frame(OTHER_MAC, 20, 1'b0, 0, 1'b1);
        exp_good = exp_good + 1'b1;
        wait_drain();
        check_counters();
        promisc_i <= 1'b0;
        report_test(2, "address filter and promiscuous");

        send_frame(STATION_MAC, 30, 1'b1, 0, 1'b0);
        exp_bad = exp_bad + 1'b1;
        send_frame(STATION_MAC, 25, 1'b0, 0, 1'b1);
        exp_good = exp_good + 1'b1;
        wait_drain();
        check_counters();
        report_test(3, "FCS error then good frame");

        ready_mode = 1;
        for (int n = 0; n < 8; n++) begin
            plen = 1 + int'($urandom % 24);
            send_frame(STATION_MAC, plen, 1'b0, 0, 1'b1);
            exp_good = exp_good + 1'b1;
        end
        wait_drain();
        ready_mode = 0;
        check_counters();
        report_test(4, "back-to-back with random ready");

        ready_mode = 2;
        send_frame(STATION_MAC, 20, 1'b0, 0, 1'b1);
        exp_good = exp_good + 1'b1;
        send_frame(STATION_MAC, `ETH_RX_FIFO_DEPTH - 4, 1'b0, 0, 1'b0);
        exp_ovf = exp_ovf + 1'b1;
        check_counters();
        ready_mode = 0;
        wait_drain();
        check_counters();
        report_test(5, "FIFO overflow");

        send_frame(STATION_MAC, 0, 1'b0, 12, 1'b0);
        exp_bad = exp_bad + 1'b1;
        wait_drain();
        check_counters();
        report_test(6, "frame cut inside header");

        $display("tests: 6  checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: eth_rx.f
+incdir+.
eth_types_pkg.sv
eth_rx_ctrl_pkg.sv
eth_frame_parser.sv
eth_fcs_checker.sv
eth_rx_fifo.sv
eth_rx_top.sv
eth_rx_props.sv
tb_eth_rx.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_eth_rx -f eth_rx.f -o Vtb_eth_rx
	./obj_dir/Vtb_eth_rx | tee sim.log
	@! grep -q "Result: FAILED" sim.log
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
